//--- common/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

  // one data or address word
  typedef logic [31:0] word_t;

  // address layout
  //   [31:6] tag
  //   [5:3]  set index
  //   [2]    word within the block
  //   [1:0]  byte offset, ignored since every access is a whole word
  localparam int TAG_W = 26;
  localparam int IDX_W = 3;

  // position of the word select bit, index and tag sit directly above it
  localparam int BLK_OFF_BIT = 2;

endpackage

`default_nettype wire

//--- common/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // cache geometry
  localparam int SETS        = 8;
  localparam int WAYS        = 2;
  localparam int BLOCK_WORDS = 2;

  // cycles dwait stays high at the start of every memory access
  localparam int MEM_WAIT = 2;

  // memory depth in words, addresses alias above 4 KB
  localparam int RAM_WORDS = 1024;

  // initial memory content is byte address xor this key
  localparam cpu_types_pkg::word_t RAM_INIT_KEY = 32'h5a5a_0000;

  // controller states
  typedef enum logic [3:0] {
    IDLE,
    WB1,
    WB2,
    FETCH1,
    FETCH2,
    FLUSH_SCAN,
    FLUSH_WB1,
    FLUSH_WB2,
    FLUSHED
  } dstate_t;

endpackage

`default_nettype wire

//--- dcache/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic [cpu_types_pkg::IDX_W-1:0] idx,
  input  logic [cpu_types_pkg::TAG_W-1:0] tag,
  input  logic                            blk_off,
  input  logic                            fill_en,
  input  logic                            fill_way,
  input  logic                            fill_off,
  input  cpu_types_pkg::word_t            fill_data,
  input  logic                            fill_done,
  input  logic                            store_en,
  input  cpu_types_pkg::word_t            store_data,
  input  logic                            touch_en,
  input  logic                            clean_en,
  input  logic                            clean_way,
  input  logic                            inval_all,
  output logic                            hit,
  output logic                            hit_way,
  output cpu_types_pkg::word_t            hit_word,
  output logic                            victim_way,
  output logic                            victim_valid,
  output logic                            victim_dirty,
  output logic [cpu_types_pkg::TAG_W-1:0] victim_tag,
  output cpu_types_pkg::word_t            victim_word0,
  output cpu_types_pkg::word_t            victim_word1
);

  logic [cpu_types_pkg::TAG_W-1:0] tag_q [cache_pkg::WAYS][cache_pkg::SETS];
  logic valid_q [cache_pkg::WAYS][cache_pkg::SETS];
  logic dirty_q [cache_pkg::WAYS][cache_pkg::SETS];
  cpu_types_pkg::word_t data_q [cache_pkg::WAYS][cache_pkg::SETS][cache_pkg::BLOCK_WORDS];

  // lru_q holds the least recently used way of each set
  logic lru_q [cache_pkg::SETS];

  logic [cache_pkg::WAYS-1:0] way_hit;

  always_comb begin
    way_hit = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++) begin
      way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];
  assign hit_word = data_q[hit_way][idx][blk_off];

  // victim is always the lru way of the addressed set
  assign victim_way   = lru_q[idx];
  assign victim_valid = valid_q[victim_way][idx];
  assign victim_dirty = dirty_q[victim_way][idx];
  assign victim_tag   = tag_q[victim_way][idx];
  assign victim_word0 = data_q[victim_way][idx][0];
  assign victim_word1 = data_q[victim_way][idx][1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      tag_q   <= '{default: '0};
      valid_q <= '{default: 1'b0};
      dirty_q <= '{default: 1'b0};
      data_q  <= '{default: '0};
      lru_q   <= '{default: 1'b0};
    end else begin
      if (fill_en) begin
        data_q[fill_way][idx][fill_off] <= fill_data;
      end
      // a completed refill also counts as a use of that way
      if (fill_done) begin
        valid_q[fill_way][idx] <= 1'b1;
        dirty_q[fill_way][idx] <= 1'b0;
        tag_q[fill_way][idx]   <= tag;
        lru_q[idx]             <= ~fill_way;
      end
      if (store_en) begin
        data_q[hit_way][idx][blk_off] <= store_data;
        dirty_q[hit_way][idx]         <= 1'b1;
      end
      if (touch_en) begin
        lru_q[idx] <= ~hit_way;
      end
      if (clean_en) begin
        dirty_q[clean_way][idx] <= 1'b0;
      end
      // placed last so it overrides any update in the same cycle
      if (inval_all) begin
        valid_q <= '{default: 1'b0};
        dirty_q <= '{default: 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

//--- dcache/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  input  logic                 halt,
  output logic                 dhit,
  output cpu_types_pkg::word_t dmemload,
  output logic                 flushed,
  output logic                 dREN,
  output logic                 dWEN,
  output cpu_types_pkg::word_t daddr,
  output cpu_types_pkg::word_t dstore,
  input  logic                 dwait,
  input  cpu_types_pkg::word_t dload
);

  cache_pkg::dstate_t state, next_state;

  logic [cpu_types_pkg::TAG_W-1:0] req_tag;
  logic [cpu_types_pkg::IDX_W-1:0] req_idx;
  logic                            req_off;
  logic                            req;

  // flush walk over the array
  // upper bits pick the set and bit 0 the pass over its two ways
  logic [cpu_types_pkg::IDX_W:0]   flush_cnt;
  logic [cpu_types_pkg::IDX_W-1:0] flush_set;
  logic                            flush_last;
  logic                            flushing;
  logic [cpu_types_pkg::IDX_W-1:0] arr_idx;

  logic                            hit;
  cpu_types_pkg::word_t            hit_word;
  logic                            victim_way;
  logic                            victim_valid;
  logic                            victim_dirty;
  logic [cpu_types_pkg::TAG_W-1:0] victim_tag;
  cpu_types_pkg::word_t            victim_word0;
  cpu_types_pkg::word_t            victim_word1;

  logic fill_en;
  logic fill_off;
  logic fill_done;
  logic store_en;
  logic touch_en;
  logic clean_en;
  logic inval_all;

  assign req_tag = dmemaddr[31 -: cpu_types_pkg::TAG_W];
  assign req_idx = dmemaddr[cpu_types_pkg::BLK_OFF_BIT+1 +: cpu_types_pkg::IDX_W];
  assign req_off = dmemaddr[cpu_types_pkg::BLK_OFF_BIT];
  assign req     = dmemREN || dmemWEN;

  assign flush_set  = flush_cnt[cpu_types_pkg::IDX_W:1];
  assign flush_last = flush_cnt[0] && (int'(flush_set) == cache_pkg::SETS - 1);
  assign flushing   = state inside {cache_pkg::FLUSH_SCAN, cache_pkg::FLUSH_WB1,
                                    cache_pkg::FLUSH_WB2};
  assign arr_idx    = flushing ? flush_set : req_idx;

  // hits complete in the request's first cycle
  assign dhit     = (state == cache_pkg::IDLE) && !halt && req && hit;
  assign dmemload = hit_word;
  assign touch_en = dhit;
  assign store_en = dhit && dmemWEN;

  dcache_array dcache_array_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .idx          (arr_idx),
    .tag          (req_tag),
    .blk_off      (req_off),
    .fill_en      (fill_en),
    .fill_way     (victim_way),
    .fill_off     (fill_off),
    .fill_data    (dload),
    .fill_done    (fill_done),
    .store_en     (store_en),
    .store_data   (dmemstore),
    .touch_en     (touch_en),
    .clean_en     (clean_en),
    .clean_way    (victim_way),
    .inval_all    (inval_all),
    .hit          (hit),
    .hit_way      (),
    .hit_word     (hit_word),
    .victim_way   (victim_way),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_word0 (victim_word0),
    .victim_word1 (victim_word1)
  );

  always_comb begin
    next_state = state;
    dREN       = 1'b0;
    dWEN       = 1'b0;
    daddr      = {req_tag, req_idx, 1'b0, {cpu_types_pkg::BLK_OFF_BIT{1'b0}}};
    dstore     = victim_word0;
    fill_en    = 1'b0;
    fill_off   = 1'b0;
    fill_done  = 1'b0;
    clean_en   = 1'b0;
    inval_all  = 1'b0;
    flushed    = 1'b0;
    case (state)
      cache_pkg::IDLE: begin
        if (halt) begin
          next_state = cache_pkg::FLUSH_SCAN;
        end else if (req && !hit) begin
          next_state = (victim_valid && victim_dirty) ? cache_pkg::WB1 : cache_pkg::FETCH1;
        end
      end
      // victim goes back to the address built from its stored tag
      cache_pkg::WB1, cache_pkg::FLUSH_WB1: begin
        dWEN  = 1'b1;
        daddr = {victim_tag, arr_idx, 1'b0, {cpu_types_pkg::BLK_OFF_BIT{1'b0}}};
        if (!dwait) begin
          next_state = (state == cache_pkg::WB1) ? cache_pkg::WB2 : cache_pkg::FLUSH_WB2;
        end
      end
      cache_pkg::WB2, cache_pkg::FLUSH_WB2: begin
        dWEN   = 1'b1;
        daddr  = {victim_tag, arr_idx, 1'b1, {cpu_types_pkg::BLK_OFF_BIT{1'b0}}};
        dstore = victim_word1;
        if (!dwait) begin
          if (state == cache_pkg::WB2) begin
            next_state = cache_pkg::FETCH1;
          end else begin
            clean_en   = 1'b1;
            next_state = cache_pkg::FLUSH_SCAN;
          end
        end
      end
      cache_pkg::FETCH1: begin
        dREN = 1'b1;
        if (!dwait) begin
          fill_en    = 1'b1;
          next_state = cache_pkg::FETCH2;
        end
      end
      cache_pkg::FETCH2: begin
        dREN  = 1'b1;
        daddr = {req_tag, req_idx, 1'b1, {cpu_types_pkg::BLK_OFF_BIT{1'b0}}};
        if (!dwait) begin
          fill_en    = 1'b1;
          fill_off   = 1'b1;
          fill_done  = 1'b1;
          next_state = cache_pkg::IDLE;
        end
      end
      cache_pkg::FLUSH_SCAN: begin
        if (victim_dirty) begin
          next_state = cache_pkg::FLUSH_WB1;
        end else begin
          // retire the clean victim so the lru bit moves to the other way
          // the whole cache is invalidated at the end of the walk
          fill_done = 1'b1;
          if (flush_last) begin
            inval_all  = 1'b1;
            next_state = cache_pkg::FLUSHED;
          end
        end
      end
      cache_pkg::FLUSHED: begin
        flushed = 1'b1;
        if (!halt) begin
          next_state = cache_pkg::IDLE;
        end
      end
      default: begin
        next_state = cache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= cache_pkg::IDLE;
      flush_cnt <= '0;
    end else begin
      state <= next_state;
      // wraps back to zero after the last way of the last set
      if (state == cache_pkg::FLUSH_SCAN && !victim_dirty) begin
        flush_cnt <= flush_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ren,
  input  logic                 wen,
  input  cpu_types_pkg::word_t addr,
  input  cpu_types_pkg::word_t wdata,
  output cpu_types_pkg::word_t rdata,
  output logic                 wait_out
);

  cpu_types_pkg::word_t mem [cache_pkg::RAM_WORDS];

  logic [$clog2(cache_pkg::RAM_WORDS)-1:0] word_idx;
  logic [$clog2(cache_pkg::MEM_WAIT+1)-1:0] wait_cnt;
  logic [$clog2(cache_pkg::MEM_WAIT+1)-1:0] elapsed;

  cpu_types_pkg::word_t last_addr;
  logic                 last_ren;
  logic                 last_wen;
  logic                 active;
  logic                 changed;
  logic                 ready;

  // upper address bits alias
  assign word_idx = addr[$clog2(cache_pkg::RAM_WORDS)+1:2];

  assign active  = ren || wen;
  assign changed = (addr != last_addr) || (ren != last_ren) || (wen != last_wen);

  // a new access starts counting from zero in its first cycle
  assign elapsed  = changed ? '0 : wait_cnt;
  assign ready    = active && (int'(elapsed) == cache_pkg::MEM_WAIT);
  assign wait_out = !ready;
  assign rdata    = mem[word_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt  <= '0;
      last_addr <= '0;
      last_ren  <= 1'b0;
      last_wen  <= 1'b0;
    end else begin
      last_addr <= addr;
      last_ren  <= ren;
      last_wen  <= wen;
      // holding the same access after completion starts a fresh one
      if (ready || !active) begin
        wait_cnt <= '0;
      end else begin
        wait_cnt <= elapsed + 1'b1;
      end
    end
  end

  always @(posedge CLK) begin
    if (wen && ready) begin
      mem[word_idx] <= wdata;
    end
  end

  // every word starts distinct and predictable
  initial begin
    for (int i = 0; i < cache_pkg::RAM_WORDS; i++) begin
      mem[i] = cpu_types_pkg::word_t'(i << 2) ^ cache_pkg::RAM_INIT_KEY;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_system.sv
`timescale 1ns/1ps
`default_nettype none

module cache_system (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  input  logic                 halt,
  output logic                 dhit,
  output cpu_types_pkg::word_t dmemload,
  output logic                 flushed
);

  // memory side of the cache
  logic                 dREN;
  logic                 dWEN;
  cpu_types_pkg::word_t daddr;
  cpu_types_pkg::word_t dstore;
  logic                 dwait;
  cpu_types_pkg::word_t dload;

  dcache dcache_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .halt      (halt),
    .dhit      (dhit),
    .dmemload  (dmemload),
    .flushed   (flushed),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .daddr     (daddr),
    .dstore    (dstore),
    .dwait     (dwait),
    .dload     (dload)
  );

  ram ram_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .ren      (dREN),
    .wen      (dWEN),
    .addr     (daddr),
    .wdata    (dstore),
    .rdata    (dload),
    .wait_out (dwait)
  );

endmodule

`default_nettype wire

//--- test/tb_cache_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_system;

  typedef cpu_types_pkg::word_t word_t;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_HALT} op_t;

  typedef struct {
    op_t   op;
    word_t addr;
    word_t data;
    bit    check;
    bit    first_hit;
  } entry_t;

  localparam word_t SEED = 32'h0fc0_ce57;
  localparam int IDX_SHIFT = cpu_types_pkg::BLK_OFF_BIT + 1;
  localparam int TAG_SHIFT = IDX_SHIFT + cpu_types_pkg::IDX_W;

  logic  CLK;
  logic  nRST;
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  halt;
  logic  dhit;
  word_t dmemload;
  logic  flushed;

  entry_t stim_q [$];
  // reference memory, keyed by word address
  word_t  ref_mem [logic [29:0]];
  word_t  rng_state;
  int     wd_cycles = 0;

  cache_system cache_system_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .halt      (halt),
    .dhit      (dhit),
    .dmemload  (dmemload),
    .flushed   (flushed)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic word_t xorshift32(input word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t make_addr(input int tag, input int idx, input int off);
    return (word_t'(tag) << TAG_SHIFT) | (word_t'(idx) << IDX_SHIFT) |
           (word_t'(off) << cpu_types_pkg::BLK_OFF_BIT);
  endfunction

  // last value written, else the memory's power-up pattern
  function automatic word_t expected_read(input word_t addr);
    logic [29:0] key;
    key = addr[31:2];
    if (ref_mem.exists(key)) begin
      return ref_mem[key];
    end
    return {key, 2'b00} ^ cache_pkg::RAM_INIT_KEY;
  endfunction

  task automatic add_entry(input op_t op, input word_t addr, input bit first_hit);
    entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.data      = '0;
    e.check     = (op == OP_READ);
    e.first_hit = first_hit;
    if (op == OP_WRITE) begin
      rng_state = xorshift32(rng_state);
      e.data    = rng_state;
    end
    stim_q.push_back(e);
  endtask

  task automatic report_mismatch(input string sig, input word_t got, input word_t want);
    $display("FAIL time %0t signal %s got %h expected %h", $time, sig, got, want);
    $display("Simulation failed");
    $fatal(1, "wrong value on %s", sig);
  endtask

  task automatic build_stimulus();
    // cold read miss, then the other word of the block
    add_entry(OP_READ, make_addr(2, 1, 0), 1'b0);
    add_entry(OP_READ, make_addr(2, 1, 1), 1'b1);
    // write allocate
    add_entry(OP_WRITE, make_addr(3, 2, 1), 1'b0);
    add_entry(OP_READ, make_addr(3, 2, 1), 1'b1);
    add_entry(OP_READ, make_addr(3, 2, 0), 1'b1);
    // lru on set 3, hit on A makes B the victim of C
    add_entry(OP_READ, make_addr(4, 3, 0), 1'b0);
    add_entry(OP_READ, make_addr(5, 3, 0), 1'b0);
    add_entry(OP_READ, make_addr(4, 3, 1), 1'b1);
    add_entry(OP_READ, make_addr(6, 3, 0), 1'b0);
    add_entry(OP_READ, make_addr(4, 3, 0), 1'b1);
    add_entry(OP_READ, make_addr(5, 3, 1), 1'b0);
    // two dirty lines on set 5 pushed out by two more tags
    add_entry(OP_WRITE, make_addr(7, 5, 0), 1'b0);
    add_entry(OP_WRITE, make_addr(8, 5, 1), 1'b0);
    add_entry(OP_READ, make_addr(9, 5, 0), 1'b0);
    add_entry(OP_READ, make_addr(10, 5, 1), 1'b0);
    add_entry(OP_READ, make_addr(7, 5, 0), 1'b0);
    add_entry(OP_READ, make_addr(7, 5, 1), 1'b1);
    add_entry(OP_READ, make_addr(8, 5, 1), 1'b0);
    // byte offset bits select nothing
    add_entry(OP_WRITE, make_addr(11, 6, 0) | 32'd1, 1'b0);
    add_entry(OP_READ, make_addr(11, 6, 0) | 32'd3, 1'b1);
    add_entry(OP_WRITE, make_addr(11, 6, 0) | 32'd2, 1'b1);
    add_entry(OP_READ, make_addr(11, 6, 0), 1'b1);
    // dirty lines in several sets, then flush
    add_entry(OP_WRITE, make_addr(12, 0, 0), 1'b0);
    add_entry(OP_WRITE, make_addr(13, 4, 1), 1'b0);
    add_entry(OP_WRITE, make_addr(14, 7, 0), 1'b0);
    add_entry(OP_WRITE, make_addr(2, 1, 1), 1'b1);
    add_entry(OP_HALT, '0, 1'b0);
    // everything was invalidated, so each read refills
    add_entry(OP_READ, make_addr(3, 2, 1), 1'b0);
    add_entry(OP_READ, make_addr(7, 5, 0), 1'b0);
    add_entry(OP_READ, make_addr(8, 5, 1), 1'b0);
    add_entry(OP_READ, make_addr(11, 6, 0), 1'b0);
    add_entry(OP_READ, make_addr(12, 0, 0), 1'b0);
    add_entry(OP_READ, make_addr(13, 4, 1), 1'b0);
    add_entry(OP_READ, make_addr(14, 7, 0), 1'b0);
    add_entry(OP_READ, make_addr(2, 1, 1), 1'b0);
    // second flush with a clean cache, walk counter wraps
    add_entry(OP_HALT, '0, 1'b0);
    add_entry(OP_READ, make_addr(13, 4, 1), 1'b0);
  endtask

  task automatic apply_access(input entry_t e);
    word_t want;
    @(posedge CLK);
    dmemREN   <= (e.op == OP_READ);
    dmemWEN   <= (e.op == OP_WRITE);
    dmemaddr  <= e.addr;
    dmemstore <= e.data;
    @(negedge CLK);
    // resident blocks complete in the first cycle
    assert (dhit === e.first_hit)
      else report_mismatch("dhit", word_t'(dhit), word_t'(e.first_hit));
    while (!dhit) begin
      @(negedge CLK);
    end
    if (e.op == OP_READ) begin
      want = expected_read(e.addr);
      if (e.check) begin
        assert (dmemload === want)
          else report_mismatch("dmemload", dmemload, want);
      end
    end else begin
      ref_mem[e.addr[31:2]] = e.data;
    end
  endtask

  task automatic apply_halt();
    @(posedge CLK);
    dmemREN <= 1'b0;
    dmemWEN <= 1'b0;
    halt    <= 1'b1;
    @(negedge CLK);
    while (!flushed) begin
      @(negedge CLK);
    end
    // flushed holds while halt is up
    @(negedge CLK);
    assert (flushed === 1'b1)
      else report_mismatch("flushed", word_t'(flushed), 32'd1);
    @(posedge CLK);
    halt <= 1'b0;
    @(negedge CLK);
    while (flushed) begin
      @(negedge CLK);
    end
  endtask

  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge CLK);
    $display("watchdog expired after %0d cycles before the tests finished", wd_cycles);
    $display("Simulation failed");
    $fatal(1, "run timed out");
  end

  initial begin
    int halts;
    nRST      <= 1'b0;
    dmemREN   <= 1'b0;
    dmemWEN   <= 1'b0;
    dmemaddr  <= '0;
    dmemstore <= '0;
    halt      <= 1'b0;
    rng_state = SEED;
    build_stimulus();
    halts = 0;
    foreach (stim_q[i]) begin
      if (stim_q[i].op == OP_HALT) begin
        halts++;
      end
    end
    // each flush may visit every line of the cache
    wd_cycles = 20 + stim_q.size() * 40 +
                halts * cache_pkg::SETS * cache_pkg::WAYS * 20;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    assert (dhit === 1'b0) else report_mismatch("dhit", word_t'(dhit), 32'd0);
    assert (flushed === 1'b0) else report_mismatch("flushed", word_t'(flushed), 32'd0);
    foreach (stim_q[i]) begin
      if (stim_q[i].op == OP_HALT) begin
        apply_halt();
      end else begin
        apply_access(stim_q[i]);
      end
    end
    @(posedge CLK);
    dmemREN <= 1'b0;
    dmemWEN <= 1'b0;
    repeat (2) @(posedge CLK);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/cpu_types_pkg.sv
common/cache_pkg.sv
dcache/dcache_array.sv
dcache/dcache.sv
source/ram.sv
source/cache_system.sv
test/tb_cache_system.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it
# the exit status of the simulation decides pass or fail

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 \
    --top-module tb_cache_system \
    -f vlog.f \
    -o tb_cache_system &&
  ./obj_dir/tb_cache_system ||
  { echo "build or simulation returned an error" >&2; exit 1; }
